//--- files.f
rtl/dcache_pkg.sv
rtl/dcache_cfg.sv
rtl/dcache_mem.sv
rtl/dcache_load_ctrl.sv
rtl/dcache_store_ctrl.sv
rtl/dcache_missunit.sv
rtl/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

//--- Makefile
SRCS := $(shell cat files.f)

.PHONY: run clean

run: obj_dir/Vtb_dcache
	@out="$$(./obj_dir/Vtb_dcache)"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

obj_dir/Vtb_dcache: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_dcache -f files.f

clean:
	rm -rf obj_dir

//--- tests/tb_dcache.sv
/*
 * testbench for the L1 data cache
 * directed loads, stores, flush and bypass checked against a shadow memory
 */
`default_nettype none

module tb_dcache;
  timeunit 1ns;
  timeprecision 100ps;
  import dcache_pkg::*;

  localparam int timeout_cycles = 200;

  logic clk_i, reset_i, enable_i, flush_i, flush_ack_o, miss_o;
  logic load_req_i, load_ack_o, store_req_i, store_ack_o;
  logic mem_req_o, mem_ack_i, mem_we_o;
  dcache_addr_u load_addr_i, store_addr_i, mem_addr_o, last_waddr;
  word_t load_rdata_o, store_wdata_i, mem_wdata_o, last_wdata;
  be_t store_be_i, mem_be_o, last_be;
  line_t mem_rline_i;
  int rd_count, wr_count, miss_count, checks, errors, proto_errors, timeouts;
  word_t shadow [1024];

  dcache_top uut (
    .clk_i(clk_i), .reset_i(reset_i), .enable_i(enable_i), .flush_i(flush_i),
    .flush_ack_o(flush_ack_o), .miss_o(miss_o),
    .load_req_i(load_req_i), .load_addr_i(load_addr_i),
    .load_ack_o(load_ack_o), .load_rdata_o(load_rdata_o),
    .store_req_i(store_req_i), .store_addr_i(store_addr_i),
    .store_wdata_i(store_wdata_i), .store_be_i(store_be_i), .store_ack_o(store_ack_o),
    .mem_req_o(mem_req_o), .mem_ack_i(mem_ack_i), .mem_we_o(mem_we_o),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_be_o(mem_be_o),
    .mem_rline_i(mem_rline_i)
  );

  tb_mem_model mem_model (
    .clk_i(clk_i), .reset_i(reset_i), .mem_req_i(mem_req_o), .mem_we_i(mem_we_o),
    .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o), .mem_be_i(mem_be_o),
    .mem_ack_o(mem_ack_i), .mem_rline_o(mem_rline_i),
    .rd_count_o(rd_count), .wr_count_o(wr_count),
    .last_waddr_o(last_waddr), .last_wdata_o(last_wdata), .last_be_o(last_be)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (!reset_i && miss_o) miss_count <= miss_count + 1;
  end

  //////////////////////////////////////////////////
  // handshake protocol
  //////////////////////////////////////////////////
  a_load_ack_held: assert property (@(posedge clk_i) disable iff (reset_i)
    load_ack_o && load_req_i |=> load_ack_o)
    else begin
      proto_errors++;
      $display("load ack dropped while load req was still high");
    end
  a_load_ack_release: assert property (@(posedge clk_i) disable iff (reset_i)
    load_ack_o && !load_req_i |=> !load_ack_o)
    else begin
      proto_errors++;
      $display("load ack stayed high after load req dropped");
    end
  a_store_ack_held: assert property (@(posedge clk_i) disable iff (reset_i)
    store_ack_o && store_req_i |=> store_ack_o)
    else begin
      proto_errors++;
      $display("store ack dropped while store req was still high");
    end
  a_store_ack_release: assert property (@(posedge clk_i) disable iff (reset_i)
    store_ack_o && !store_req_i |=> !store_ack_o)
    else begin
      proto_errors++;
      $display("store ack stayed high after store req dropped");
    end
  a_flush_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_ack_o |=> !flush_ack_o)
    else begin
      proto_errors++;
      $display("flush ack was high for more than one cycle");
    end
  a_mem_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && !mem_ack_i |=> mem_req_o)
    else begin
      proto_errors++;
      $display("memory req dropped before memory ack");
    end
  // line reads only happen for the load in flight
  a_mem_read_line: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && !mem_we_o |-> mem_addr_o.raw == {load_addr_i.raw[31:4], 4'h0})
    else begin
      proto_errors++;
      $display("memory read address is not the aligned line of the load");
    end

  function automatic word_t fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ 32'h3c5a_96e1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout waiting for %s", what);
  endtask

  task automatic load_word(input string name, input logic [31:0] addr, input int exp_miss);
    word_t exp;
    int rd0, miss0, n;
    if (timeouts != 0) return;
    exp   = shadow[addr[11:2]];
    rd0   = rd_count;
    miss0 = miss_count;
    load_addr_i.raw = addr;
    load_req_i      = 1'b1;
    for (n = 0; !load_ack_o && n < timeout_cycles; n++) @(negedge clk_i);
    if (!load_ack_o) begin
      report_timeout({name, " load ack"});
      return;
    end
    check_value({name, "_data"}, exp, load_rdata_o);
    // keep req up a little while the ack must hold
    repeat ($urandom_range(2, 0)) @(negedge clk_i);
    load_req_i = 1'b0;
    for (n = 0; load_ack_o && n < timeout_cycles; n++) @(negedge clk_i);
    if (load_ack_o) begin
      report_timeout({name, " load ack to drop"});
      return;
    end
    check_value({name, "_reads"}, exp_miss, rd_count - rd0);
    check_value({name, "_misses"}, exp_miss, miss_count - miss0);
  endtask

  task automatic store_word(input string name, input logic [31:0] addr, input word_t data,
                            input be_t be);
    int rd0, wr0, n;
    if (timeouts != 0) return;
    rd0 = rd_count;
    wr0 = wr_count;
    store_addr_i.raw = addr;
    store_wdata_i    = data;
    store_be_i       = be;
    store_req_i      = 1'b1;
    for (n = 0; !store_ack_o && n < timeout_cycles; n++) @(negedge clk_i);
    if (!store_ack_o) begin
      report_timeout({name, " store ack"});
      return;
    end
    // memory write is already done when the core sees the ack
    check_value({name, "_writes"}, 1, wr_count - wr0);
    check_value({name, "_reads"}, 0, rd_count - rd0);
    check_value({name, "_addr"}, addr, last_waddr.raw);
    check_value({name, "_wdata"}, data, last_wdata);
    check_value({name, "_be"}, 32'(be), 32'(last_be));
    for (int b = 0; b < 4; b++) begin
      if (be[b]) shadow[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
    end
    repeat ($urandom_range(2, 0)) @(negedge clk_i);
    store_req_i = 1'b0;
    for (n = 0; store_ack_o && n < timeout_cycles; n++) @(negedge clk_i);
    if (store_ack_o) report_timeout({name, " store ack to drop"});
  endtask

  task automatic flush_cache();
    int n;
    if (timeouts != 0) return;
    flush_i = 1'b1;
    for (n = 0; !flush_ack_o && n < timeout_cycles; n++) @(negedge clk_i);
    if (!flush_ack_o) begin
      report_timeout("flush ack");
      return;
    end
    @(negedge clk_i);
    check_value("flush_pulse", 0, 32'(flush_ack_o));
    flush_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(90));
    reset_i       = 1'b1;
    enable_i      = 1'b1;
    flush_i       = 1'b0;
    load_req_i    = 1'b0;
    load_addr_i   = '0;
    store_req_i   = 1'b0;
    store_addr_i  = '0;
    store_wdata_i = '0;
    store_be_i    = '0;
    for (int i = 0; i < 1024; i++) shadow[i] = fill_word(32'(i) << 2);
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    check_value("reset_outputs", 0,
                32'({load_ack_o, store_ack_o, flush_ack_o, miss_o, mem_req_o}));
    // enable register needs a cycle to pick up enable_i
    repeat (2) @(negedge clk_i);

    load_word("ld_miss", 32'h0000_0100, 1);
    load_word("ld_hit", 32'h0000_0104, 0);
    load_word("ld_miss_b", 32'h0000_0240, 1);

    store_word("st_hit", 32'h0000_0108, 32'hcafe_f00d, 4'b0101);
    load_word("st_hit_ld", 32'h0000_0108, 0);

    // no allocate, so the next load goes to memory
    store_word("st_miss", 32'h0000_0384, 32'h1234_5678, 4'b1111);
    load_word("st_miss_ld", 32'h0000_0384, 1);
    load_word("st_miss_ld_hit", 32'h0000_0384, 0);

    flush_cache();
    load_word("flush_ld_a", 32'h0000_0100, 1);
    load_word("flush_ld_b", 32'h0000_0240, 1);

    // bypass even though the line is cached
    enable_i = 1'b0;
    repeat (2) @(negedge clk_i);
    for (int k = 0; k < 3; k++) load_word("bypass_ld", 32'h0000_0104, 1);

    repeat (2) @(negedge clk_i);
    $display("checks %0d, check errors %0d, protocol errors %0d, timeouts %0d",
             checks, errors, proto_errors, timeouts);
    if (errors == 0 && proto_errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
/*
 * memory model for the cache memory port
 * four-phase responder with random ack delay over a 4 KiB word array,
 * counts line reads and word writes and keeps the last write
 */
`default_nettype none

module tb_mem_model (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     mem_req_i,
  input  logic                     mem_we_i,
  input  dcache_pkg::dcache_addr_u mem_addr_i,
  input  dcache_pkg::word_t        mem_wdata_i,
  input  dcache_pkg::be_t          mem_be_i,
  output logic                     mem_ack_o,
  output dcache_pkg::line_t        mem_rline_o,
  output int                       rd_count_o,
  output int                       wr_count_o,
  output dcache_pkg::dcache_addr_u last_waddr_o,
  output dcache_pkg::word_t        last_wdata_o,
  output dcache_pkg::be_t          last_be_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import dcache_pkg::*;

  word_t ram [1024];
  logic  busy_q;
  int    delay_q;

  // initial contents, every word differs
  function automatic word_t fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ 32'h3c5a_96e1;
  endfunction

  // outputs change on the falling edge, like the rest of the stimulus
  always @(negedge clk_i) begin
    if (reset_i) begin
      mem_ack_o    <= 1'b0;
      busy_q       <= 1'b0;
      delay_q      <= 0;
      rd_count_o   <= 0;
      wr_count_o   <= 0;
      last_waddr_o <= '0;
      last_wdata_o <= '0;
      last_be_o    <= '0;
      for (int i = 0; i < 1024; i++) begin
        ram[i] <= fill_word(32'(i) << 2);
      end
    end else if (mem_ack_o) begin
      // ack stays up until the request drops
      if (!mem_req_i) mem_ack_o <= 1'b0;
    end else if (mem_req_i && !busy_q) begin
      busy_q  <= 1'b1;
      delay_q <= $urandom_range(4, 0);
    end else if (busy_q && delay_q != 0) begin
      delay_q <= delay_q - 1;
    end else if (busy_q) begin
      busy_q    <= 1'b0;
      mem_ack_o <= 1'b1;
      if (mem_we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_be_i[b]) begin
            ram[mem_addr_i.raw[11:2]][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
          end
        end
        wr_count_o   <= wr_count_o + 1;
        last_waddr_o <= mem_addr_i;
        last_wdata_o <= mem_wdata_i;
        last_be_o    <= mem_be_i;
      end else begin
        // whole line, word 0 in the low bits
        for (int w = 0; w < words_per_line; w++) begin
          mem_rline_o[w*word_w +: word_w] <= ram[{mem_addr_i.raw[11:4], 2'(w)}];
        end
        rd_count_o <= rd_count_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
/*
 * L1 data cache top
 * direct-mapped write-through cache, one load port, one store port
 */
`default_nettype none

module dcache_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     enable_i,
  input  logic                     flush_i,
  output logic                     flush_ack_o,
  output logic                     miss_o,
  input  logic                     load_req_i,
  input  dcache_pkg::dcache_addr_u load_addr_i,
  output logic                     load_ack_o,
  output dcache_pkg::word_t        load_rdata_o,
  input  logic                     store_req_i,
  input  dcache_pkg::dcache_addr_u store_addr_i,
  input  dcache_pkg::word_t        store_wdata_i,
  input  dcache_pkg::be_t          store_be_i,
  output logic                     store_ack_o,
  output logic                     mem_req_o,
  input  logic                     mem_ack_i,
  output logic                     mem_we_o,
  output dcache_pkg::dcache_addr_u mem_addr_o,
  output dcache_pkg::word_t        mem_wdata_o,
  output dcache_pkg::be_t          mem_be_o,
  input  dcache_pkg::line_t        mem_rline_i
);
  import dcache_pkg::*;

  // configuration
  logic cache_en, hold, inv, ld_idle, st_idle;
  index_t inv_index;

  // lookups and array writes
  logic ld_lu_req, ld_lu_gnt, ld_hit, st_lu_req, st_lu_gnt, st_hit;
  dcache_addr_u ld_lu_addr, st_lu_addr, rf_addr, st_waddr;
  word_t ld_rdata, st_wdata;
  logic rf_we, st_we;
  line_t rf_line;
  be_t st_wbe;

  // miss unit requests
  logic ld_miss_req, ld_miss_ack, st_wt_req, st_wt_ack;
  dcache_addr_u ld_miss_addr, st_wt_addr;
  line_t miss_rline;
  word_t st_wt_data;
  be_t st_wt_be;

  dcache_cfg i_cfg (
    .clk_i(clk_i), .reset_i(reset_i), .enable_i(enable_i), .flush_i(flush_i),
    .ld_idle_i(ld_idle), .st_idle_i(st_idle), .flush_ack_o(flush_ack_o),
    .cache_en_o(cache_en), .hold_o(hold), .inv_o(inv), .inv_index_o(inv_index)
  );

  dcache_mem i_mem (
    .clk_i(clk_i), .reset_i(reset_i),
    .ld_lu_req_i(ld_lu_req), .ld_lu_addr_i(ld_lu_addr), .ld_lu_gnt_o(ld_lu_gnt),
    .ld_hit_o(ld_hit), .ld_rdata_o(ld_rdata),
    .st_lu_req_i(st_lu_req), .st_lu_addr_i(st_lu_addr), .st_lu_gnt_o(st_lu_gnt),
    .st_hit_o(st_hit),
    .rf_we_i(rf_we), .rf_addr_i(rf_addr), .rf_line_i(rf_line),
    .st_we_i(st_we), .st_waddr_i(st_waddr), .st_wdata_i(st_wdata), .st_wbe_i(st_wbe),
    .inv_i(inv), .inv_index_i(inv_index)
  );

  dcache_load_ctrl i_load_ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .load_req_i(load_req_i), .load_addr_i(load_addr_i),
    .load_ack_o(load_ack_o), .load_rdata_o(load_rdata_o), .miss_o(miss_o),
    .cache_en_i(cache_en), .hold_i(hold), .ld_idle_o(ld_idle),
    .ld_lu_req_o(ld_lu_req), .ld_lu_addr_o(ld_lu_addr), .ld_lu_gnt_i(ld_lu_gnt),
    .ld_hit_i(ld_hit), .ld_rdata_i(ld_rdata),
    .ld_miss_req_o(ld_miss_req), .ld_miss_addr_o(ld_miss_addr),
    .ld_miss_ack_i(ld_miss_ack), .miss_rline_i(miss_rline),
    .rf_we_o(rf_we), .rf_addr_o(rf_addr), .rf_line_o(rf_line)
  );

  dcache_store_ctrl i_store_ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .store_req_i(store_req_i), .store_addr_i(store_addr_i),
    .store_wdata_i(store_wdata_i), .store_be_i(store_be_i), .store_ack_o(store_ack_o),
    .hold_i(hold), .st_idle_o(st_idle),
    .st_lu_req_o(st_lu_req), .st_lu_addr_o(st_lu_addr), .st_lu_gnt_i(st_lu_gnt),
    .st_hit_i(st_hit),
    .st_wt_req_o(st_wt_req), .st_wt_addr_o(st_wt_addr), .st_wt_data_o(st_wt_data),
    .st_wt_be_o(st_wt_be), .st_wt_ack_i(st_wt_ack),
    .st_we_o(st_we), .st_waddr_o(st_waddr), .st_wdata_o(st_wdata), .st_wbe_o(st_wbe)
  );

  dcache_missunit i_missunit (
    .clk_i(clk_i), .reset_i(reset_i),
    .ld_miss_req_i(ld_miss_req), .ld_miss_addr_i(ld_miss_addr),
    .ld_miss_ack_o(ld_miss_ack), .miss_rline_o(miss_rline),
    .st_wt_req_i(st_wt_req), .st_wt_addr_i(st_wt_addr), .st_wt_data_i(st_wt_data),
    .st_wt_be_i(st_wt_be), .st_wt_ack_o(st_wt_ack),
    .mem_req_o(mem_req_o), .mem_ack_i(mem_ack_i), .mem_we_o(mem_we_o),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_be_o(mem_be_o),
    .mem_rline_i(mem_rline_i)
  );

endmodule

`default_nettype wire

//--- rtl/dcache_missunit.sv
/*
 * miss unit
 * single memory channel shared by load refills and store write-throughs
 */
`default_nettype none

module dcache_missunit (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     ld_miss_req_i,
  input  dcache_pkg::dcache_addr_u ld_miss_addr_i,
  output logic                     ld_miss_ack_o,
  output dcache_pkg::line_t        miss_rline_o,
  input  logic                     st_wt_req_i,
  input  dcache_pkg::dcache_addr_u st_wt_addr_i,
  input  dcache_pkg::word_t        st_wt_data_i,
  input  dcache_pkg::be_t          st_wt_be_i,
  output logic                     st_wt_ack_o,
  output logic                     mem_req_o,
  input  logic                     mem_ack_i,
  output logic                     mem_we_o,
  output dcache_pkg::dcache_addr_u mem_addr_o,
  output dcache_pkg::word_t        mem_wdata_o,
  output dcache_pkg::be_t          mem_be_o,
  input  dcache_pkg::line_t        mem_rline_i
);
  import dcache_pkg::*;

  localparam logic [1:0] M_IDLE  = 2'd0;
  localparam logic [1:0] M_MEM   = 2'd1;
  localparam logic [1:0] M_MDROP = 2'd2;
  localparam logic [1:0] M_ACK   = 2'd3;

  logic [1:0]   state_q;
  logic         sel_st_q;
  logic         we_q;
  dcache_addr_u addr_q;
  word_t        wdata_q;
  be_t          be_q;
  line_t        rline_q;

  ////////////////////////////////////////////////////
  // arbitration and memory handshake
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= M_IDLE;
      sel_st_q <= 1'b0;
    end else begin
      case (state_q)
        M_IDLE: begin
          // load miss first
          if (ld_miss_req_i || st_wt_req_i) begin
            sel_st_q <= !ld_miss_req_i;
            state_q  <= M_MEM;
          end
        end
        M_MEM: if (mem_ack_i) state_q <= M_MDROP;
        M_MDROP: if (!mem_ack_i) state_q <= M_ACK;
        M_ACK: begin
          if (sel_st_q ? !st_wt_req_i : !ld_miss_req_i) state_q <= M_IDLE;
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  // payload is latched at accept and held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (state_q == M_IDLE) begin
      if (ld_miss_req_i) begin
        we_q              <= 1'b0;
        addr_q            <= ld_miss_addr_i;
        addr_q.f.word_sel <= '0;
        addr_q.f.byte_off <= '0;
        wdata_q           <= '0;
        be_q              <= '0;
      end else begin
        we_q    <= 1'b1;
        addr_q  <= st_wt_addr_i;
        wdata_q <= st_wt_data_i;
        be_q    <= st_wt_be_i;
      end
    end
    if (state_q == M_MEM && mem_ack_i) rline_q <= mem_rline_i;
  end

  assign mem_req_o     = (state_q == M_MEM);
  assign mem_we_o      = we_q;
  assign mem_addr_o    = addr_q;
  assign mem_wdata_o   = wdata_q;
  assign mem_be_o      = be_q;
  assign miss_rline_o  = rline_q;
  assign ld_miss_ack_o = (state_q == M_ACK) && !sel_st_q;
  assign st_wt_ack_o   = (state_q == M_ACK) && sel_st_q;

  a_served_req_held: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_req_o |-> (sel_st_q ? st_wt_req_i : ld_miss_req_i))
    else $error("request dropped before its memory transfer ended");

endmodule

`default_nettype wire

//--- rtl/dcache_store_ctrl.sv
/*
 * store port controller
 * lookup, write-through to memory, then word update on a hit
 */
`default_nettype none

module dcache_store_ctrl (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     store_req_i,
  input  dcache_pkg::dcache_addr_u store_addr_i,
  input  dcache_pkg::word_t        store_wdata_i,
  input  dcache_pkg::be_t          store_be_i,
  output logic                     store_ack_o,
  input  logic                     hold_i,
  output logic                     st_idle_o,
  output logic                     st_lu_req_o,
  output dcache_pkg::dcache_addr_u st_lu_addr_o,
  input  logic                     st_lu_gnt_i,
  input  logic                     st_hit_i,
  output logic                     st_wt_req_o,
  output dcache_pkg::dcache_addr_u st_wt_addr_o,
  output dcache_pkg::word_t        st_wt_data_o,
  output dcache_pkg::be_t          st_wt_be_o,
  input  logic                     st_wt_ack_i,
  output logic                     st_we_o,
  output dcache_pkg::dcache_addr_u st_waddr_o,
  output dcache_pkg::word_t        st_wdata_o,
  output dcache_pkg::be_t          st_wbe_o
);
  import dcache_pkg::*;

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_LOOKUP = 3'd1;
  localparam logic [2:0] S_RESULT = 3'd2;
  localparam logic [2:0] S_WT     = 3'd3;
  localparam logic [2:0] S_WDROP  = 3'd4;
  localparam logic [2:0] S_UPDATE = 3'd5;
  localparam logic [2:0] S_ACK    = 3'd6;

  logic [2:0]   state_q;
  logic         hit_q;
  dcache_addr_u addr_q;
  word_t        data_q;
  be_t          be_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
      hit_q   <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (store_req_i && !hold_i) state_q <= S_LOOKUP;
        S_LOOKUP: if (st_lu_gnt_i) state_q <= S_RESULT;
        S_RESULT: begin
          hit_q   <= st_hit_i;
          state_q <= S_WT;
        end
        S_WT: if (st_wt_ack_i) state_q <= S_WDROP;
        // no allocate on a miss, memory already has the data
        S_WDROP: if (!st_wt_ack_i) state_q <= hit_q ? S_UPDATE : S_ACK;
        S_UPDATE: state_q <= S_ACK;
        S_ACK: if (!store_req_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE) begin
      addr_q <= store_addr_i;
      data_q <= store_wdata_i;
      be_q   <= store_be_i;
    end
  end

  assign st_idle_o    = (state_q == S_IDLE);
  assign st_lu_req_o  = (state_q == S_LOOKUP);
  assign st_lu_addr_o = addr_q;
  assign st_wt_req_o  = (state_q == S_WT);
  assign st_wt_addr_o = addr_q;
  assign st_wt_data_o = data_q;
  assign st_wt_be_o   = be_q;
  assign st_we_o      = (state_q == S_UPDATE);
  assign st_waddr_o   = addr_q;
  assign st_wdata_o   = data_q;
  assign st_wbe_o     = be_q;
  assign store_ack_o  = (state_q == S_ACK);

endmodule

`default_nettype wire

//--- rtl/dcache_load_ctrl.sv
/*
 * load port controller
 * lookup, miss fetch, refill and four-phase answer to the core
 */
`default_nettype none

module dcache_load_ctrl (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     load_req_i,
  input  dcache_pkg::dcache_addr_u load_addr_i,
  output logic                     load_ack_o,
  output dcache_pkg::word_t        load_rdata_o,
  output logic                     miss_o,
  input  logic                     cache_en_i,
  input  logic                     hold_i,
  output logic                     ld_idle_o,
  output logic                     ld_lu_req_o,
  output dcache_pkg::dcache_addr_u ld_lu_addr_o,
  input  logic                     ld_lu_gnt_i,
  input  logic                     ld_hit_i,
  input  dcache_pkg::word_t        ld_rdata_i,
  output logic                     ld_miss_req_o,
  output dcache_pkg::dcache_addr_u ld_miss_addr_o,
  input  logic                     ld_miss_ack_i,
  input  dcache_pkg::line_t        miss_rline_i,
  output logic                     rf_we_o,
  output dcache_pkg::dcache_addr_u rf_addr_o,
  output dcache_pkg::line_t        rf_line_o
);
  import dcache_pkg::*;

  localparam logic [2:0] L_IDLE   = 3'd0;
  localparam logic [2:0] L_LOOKUP = 3'd1;
  localparam logic [2:0] L_RESULT = 3'd2;
  localparam logic [2:0] L_MISS   = 3'd3;
  localparam logic [2:0] L_MDROP  = 3'd4;
  localparam logic [2:0] L_REFILL = 3'd5;
  localparam logic [2:0] L_ACK    = 3'd6;

  logic [2:0]   state_q;
  logic         miss_q;
  dcache_addr_u addr_q;
  word_t        rdata_q;
  line_t        line_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= L_IDLE;
      miss_q  <= 1'b0;
    end else begin
      miss_q <= 1'b0;
      case (state_q)
        L_IDLE: begin
          if (load_req_i && !hold_i) begin
            // disabled cache goes straight to memory
            state_q <= cache_en_i ? L_LOOKUP : L_MISS;
            miss_q  <= !cache_en_i;
          end
        end
        L_LOOKUP: if (ld_lu_gnt_i) state_q <= L_RESULT;
        L_RESULT: begin
          state_q <= ld_hit_i ? L_ACK : L_MISS;
          miss_q  <= !ld_hit_i;
        end
        L_MISS: if (ld_miss_ack_i) state_q <= L_MDROP;
        L_MDROP: if (!ld_miss_ack_i) state_q <= cache_en_i ? L_REFILL : L_ACK;
        L_REFILL: state_q <= L_ACK;
        L_ACK: if (!load_req_i) state_q <= L_IDLE;
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (state_q == L_IDLE) addr_q <= load_addr_i;
    if (state_q == L_RESULT) rdata_q <= ld_rdata_i;
    if (state_q == L_MISS && ld_miss_ack_i) begin
      line_q  <= miss_rline_i;
      rdata_q <= miss_rline_i[addr_q.f.word_sel*word_w +: word_w];
    end
  end

  assign ld_idle_o      = (state_q == L_IDLE);
  assign ld_lu_req_o    = (state_q == L_LOOKUP);
  assign ld_lu_addr_o   = addr_q;
  assign ld_miss_req_o  = (state_q == L_MISS);
  assign ld_miss_addr_o = addr_q;
  assign rf_we_o        = (state_q == L_REFILL);
  assign rf_addr_o      = addr_q;
  assign rf_line_o      = line_q;
  assign load_ack_o     = (state_q == L_ACK);
  assign load_rdata_o   = rdata_q;
  assign miss_o         = miss_q;

endmodule

`default_nettype wire

//--- rtl/dcache_mem.sv
/*
 * cache arrays
 * valid bits, tags and lines, lookup arbitration and tag compare
 */
`default_nettype none

module dcache_mem (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     ld_lu_req_i,
  input  dcache_pkg::dcache_addr_u ld_lu_addr_i,
  output logic                     ld_lu_gnt_o,
  output logic                     ld_hit_o,
  output dcache_pkg::word_t        ld_rdata_o,
  input  logic                     st_lu_req_i,
  input  dcache_pkg::dcache_addr_u st_lu_addr_i,
  output logic                     st_lu_gnt_o,
  output logic                     st_hit_o,
  input  logic                     rf_we_i,
  input  dcache_pkg::dcache_addr_u rf_addr_i,
  input  dcache_pkg::line_t        rf_line_i,
  input  logic                     st_we_i,
  input  dcache_pkg::dcache_addr_u st_waddr_i,
  input  dcache_pkg::word_t        st_wdata_i,
  input  dcache_pkg::be_t          st_wbe_i,
  input  logic                     inv_i,
  input  dcache_pkg::index_t       inv_index_i
);
  import dcache_pkg::*;

  logic [num_sets-1:0] valid_q;
  tag_t                tag_q [num_sets];
  line_t               data_q [num_sets];
  logic                ld_hit_q, st_hit_q;
  word_t               ld_rdata_q;

  function automatic logic tag_match(dcache_addr_u a);
    return valid_q[a.f.index] && (tag_q[a.f.index] == a.f.tag);
  endfunction

  ////////////////////////////////////////////////////
  // lookup grant, writes win over both lookups
  ////////////////////////////////////////////////////
  assign ld_lu_gnt_o = ld_lu_req_i && !(inv_i || rf_we_i || st_we_i);
  assign st_lu_gnt_o = st_lu_req_i && !ld_lu_req_i && !(inv_i || rf_we_i || st_we_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ld_hit_q <= 1'b0;
      st_hit_q <= 1'b0;
    end else begin
      if (ld_lu_gnt_o) ld_hit_q <= tag_match(ld_lu_addr_i);
      if (st_lu_gnt_o) st_hit_q <= tag_match(st_lu_addr_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_lu_gnt_o) begin
      ld_rdata_q <= data_q[ld_lu_addr_i.f.index][ld_lu_addr_i.f.word_sel*word_w +: word_w];
    end
  end

  ////////////////////////////////////////////////////
  // writes: inv, then refill, then word update
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (inv_i) begin
      valid_q[inv_index_i] <= 1'b0;
    end else if (rf_we_i) begin
      valid_q[rf_addr_i.f.index] <= 1'b1;
    end
  end

  // word update rechecks the tag in case a refill replaced the line
  always_ff @(posedge clk_i) begin
    if (!inv_i && rf_we_i) begin
      tag_q[rf_addr_i.f.index]  <= rf_addr_i.f.tag;
      data_q[rf_addr_i.f.index] <= rf_line_i;
    end else if (!inv_i && st_we_i && tag_match(st_waddr_i)) begin
      for (int b = 0; b < word_w / 8; b++) begin
        if (st_wbe_i[b]) begin
          data_q[st_waddr_i.f.index][st_waddr_i.f.word_sel*word_w + b*8 +: 8] <=
            st_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign ld_hit_o   = ld_hit_q;
  assign ld_rdata_o = ld_rdata_q;
  assign st_hit_o   = st_hit_q;

  a_one_line_writer: assert property (
    @(posedge clk_i) disable iff (reset_i) !(rf_we_i && st_we_i))
    else $error("refill and word update in the same cycle");

endmodule

`default_nettype wire

//--- rtl/dcache_cfg.sv
/*
 * cache configuration block
 * registers the enable and walks all sets to invalidate them on a flush
 */
`default_nettype none

module dcache_cfg (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               enable_i,
  input  logic               flush_i,
  input  logic               ld_idle_i,
  input  logic               st_idle_i,
  output logic               flush_ack_o,
  output logic               cache_en_o,
  output logic               hold_o,
  output logic               inv_o,
  output dcache_pkg::index_t inv_index_o
);
  import dcache_pkg::*;

  localparam logic [2:0] C_IDLE  = 3'd0;
  localparam logic [2:0] C_DRAIN = 3'd1;
  localparam logic [2:0] C_INV   = 3'd2;
  localparam logic [2:0] C_ACK   = 3'd3;
  localparam logic [2:0] C_WAIT  = 3'd4;

  logic [2:0] state_q;
  logic       en_q;
  index_t     idx_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= C_IDLE;
      en_q    <= 1'b0;
      idx_q   <= '0;
    end else begin
      en_q <= enable_i;
      case (state_q)
        C_IDLE: if (flush_i) state_q <= C_DRAIN;
        // hold is already up, so idle controllers stay idle
        C_DRAIN: begin
          if (ld_idle_i && st_idle_i) begin
            state_q <= C_INV;
            idx_q   <= '0;
          end
        end
        C_INV: begin
          idx_q <= idx_q + 1'b1;
          if (idx_q == index_t'(num_sets - 1)) state_q <= C_ACK;
        end
        C_ACK: state_q <= C_WAIT;
        C_WAIT: if (!flush_i) state_q <= C_IDLE;
        default: state_q <= C_IDLE;
      endcase
    end
  end

  assign cache_en_o  = en_q;
  assign hold_o      = (state_q != C_IDLE);
  assign inv_o       = (state_q == C_INV);
  assign inv_index_o = idx_q;
  assign flush_ack_o = (state_q == C_ACK);

  a_inv_when_idle: assert property (
    @(posedge clk_i) disable iff (reset_i) inv_o |-> ld_idle_i && st_idle_i)
    else $error("set invalidated while a controller was busy");

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
/*
 * L1 data cache package
 * word, line and tag types plus the address layout shared by all blocks
 */
`default_nettype none

package dcache_pkg;

  localparam int word_w         = 32;
  localparam int words_per_line = 4;
  localparam int offset_w       = 4;
  localparam int index_w        = 6;
  localparam int tag_w          = 22;
  localparam int num_sets       = 1 << index_w;

  typedef logic [word_w-1:0]                word_t;
  typedef logic [word_w/8-1:0]              be_t;
  typedef logic [words_per_line*word_w-1:0] line_t;
  typedef logic [tag_w-1:0]                 tag_t;
  typedef logic [index_w-1:0]               index_t;

  // raw word on the ports, split into fields inside the arrays
  typedef union packed {
    logic [tag_w+index_w+offset_w-1:0] raw;
    struct packed {
      tag_t                tag;
      index_t              index;
      logic [offset_w-3:0] word_sel;
      logic [1:0]          byte_off;
    } f;
  } dcache_addr_u;

endpackage

`default_nettype wire
